// ==== hdl/regex_cfg.svh ====
`ifndef REGEX_CFG_SVH
`define REGEX_CFG_SVH

// Sizing of the stream-aware matcher

// Number of interleaved streams
// Also the depth of each per-stream context store
`define NUM_STREAMS 64

// Width of the stream index
// Must cover NUM_STREAMS entries
`define STREAM_ID_W 6

// Per-stream hit count width
// The count wraps when it overflows
`define COUNT_W 16

// Width of one DFA state
// Six states for the word "login" fit in three bits
`define DFA_STATE_W 3

`endif

// ==== hdl/dfa_pkg.sv ====
`default_nettype none

`include "regex_cfg.svh"

package dfa_pkg;

  // One DFA state, also the payload of the state store
  typedef logic [`DFA_STATE_W-1:0] dfa_state_t;

  // One input byte
  typedef logic [7:0] dfa_char_t;

  // States of the "login" recognizer
  // Each one names the prefix seen so far
  localparam dfa_state_t S_IDLE  = dfa_state_t'(0);
  localparam dfa_state_t S_L     = dfa_state_t'(1);
  localparam dfa_state_t S_LO    = dfa_state_t'(2);
  localparam dfa_state_t S_LOG   = dfa_state_t'(3);
  localparam dfa_state_t S_LOGI  = dfa_state_t'(4);
  // Full word seen, acts like S_IDLE for the next byte
  localparam dfa_state_t S_MATCH = dfa_state_t'(5);

endpackage

`default_nettype wire

// ==== hdl/stream_pkg.sv ====
`default_nettype none

`include "regex_cfg.svh"

package stream_pkg;

  // Index of one stream
  typedef logic [`STREAM_ID_W-1:0] stream_id_t;

  // Hit count kept per stream, wraps on overflow
  typedef logic [`COUNT_W-1:0] hit_count_t;

  // Packet control FSM states
  // IDLE    waiting for pkt_start
  // LOAD    store read data valid, context loaded at end of cycle
  // RUN     characters accepted until pkt_end
  // DRAIN   two cycles for the last accept to reach the flag
  // COMMIT  write back and report the count
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    LOAD   = 3'd1,
    RUN    = 3'd2,
    DRAIN  = 3'd3,
    COMMIT = 3'd4
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/context_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regex_cfg.svh"

// Per-stream context memory
// One entry per stream, registered read, single write port
module context_store
  import stream_pkg::*;
#(
  parameter type payload_t = hit_count_t
) (
  input  wire logic       clk,
  input  wire stream_id_t rd_addr,
  input  wire logic       wr_en,
  input  wire stream_id_t wr_addr,
  input  wire payload_t   wr_data,
  output payload_t        rd_data
);

  // Contents are undefined until a stream's first commit
  // A first packet comes with new_stream, so the read value is never used
  payload_t mem [`NUM_STREAMS];

  // Write at commit
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read every cycle, data shows up one cycle after the address
  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== hdl/login_dfa.sv ====
`timescale 1ns/1ps
`default_nettype none

// Fixed DFA for the case-insensitive word "login"
// Input byte is registered first and then takes one transition per valid byte
module login_dfa
  import dfa_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       load_ctx,
  input  wire dfa_state_t restore_state,
  input  wire logic       char_vld,
  input  wire dfa_char_t  char_in,
  output dfa_state_t      next_state,
  output logic            accept
);

  // Input stage
  dfa_char_t  char_q;
  logic       vld_q;

  // Current DFA state and its successor
  dfa_state_t state_q;
  dfa_state_t state_d;

  // One transition with case folding
  function automatic dfa_state_t step(input dfa_state_t cur, input dfa_char_t ch);
    dfa_char_t  lc;
    dfa_char_t  want;
    dfa_state_t adv;
    // Fold upper case letters to lower case
    lc = ((ch >= "A") && (ch <= "Z")) ? (ch | 8'h20) : ch;
    // Letter that extends the current prefix
    case (cur)
      S_L:     want = "o";
      S_LO:    want = "g";
      S_LOG:   want = "i";
      S_LOGI:  want = "n";
      // S_IDLE and S_MATCH both wait for the first letter
      default: want = "l";
    endcase
    // State reached by that letter
    case (cur)
      S_L:     adv = S_LO;
      S_LO:    adv = S_LOG;
      S_LOG:   adv = S_LOGI;
      S_LOGI:  adv = S_MATCH;
      default: adv = S_L;
    endcase
    if (lc == want)
      return adv;
    // A stray 'l' can still start a new word
    else if (lc == "l")
      return S_L;
    else
      return S_IDLE;
  endfunction

  // Register the character and its strobe
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      vld_q <= 1'b0;
    else
      vld_q <= char_vld;
  end

  always_ff @(posedge clk)
  begin
    char_q <= char_in;
  end

  always_comb
  begin
    state_d = step(state_q, char_q);
  end

  // State and accept flag
  // A restored context replaces the state on load
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= S_IDLE;
      accept  <= 1'b0;
    end
    else if (load_ctx)
    begin
      state_q <= restore_state;
      accept  <= 1'b0;
    end
    else
    begin
      if (vld_q)
        state_q <= state_d;
      // Accept rises only on entry into S_MATCH
      accept <= vld_q && (state_d == S_MATCH);
    end
  end

  // Held state goes to the state store write port
  assign next_state = state_q;

endmodule

`default_nettype wire

// ==== hdl/hit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Speculative match flag for the current packet and the stream count
// The flag only counts once the packet commits on an enabled stream
module hit_counter
  import stream_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       load_ctx,
  input  wire hit_count_t base_count,
  input  wire logic       accept,
  input  wire logic       commit,
  input  wire logic       cur_enable,
  output logic            fired,
  output hit_count_t      stream_count,
  output logic            count_vld
);

  // Count restored for this stream at load
  hit_count_t base_q;
  // At least one match seen in this packet
  logic       flag_q;

  always_ff @(posedge clk)
  begin
    if (load_ctx)
      base_q <= base_count;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      flag_q <= 1'b0;
    // New packet starts clean
    else if (load_ctx)
      flag_q <= 1'b0;
    // Disabled packet drops its match
    else if (commit && !cur_enable)
      flag_q <= 1'b0;
    else if (accept)
      flag_q <= 1'b1;
  end

  assign fired = flag_q;

  // Plus one per matched packet, never more
  // Wraps at the top of the range
  assign stream_count = base_q + hit_count_t'(flag_q && cur_enable);

  // Count is reported in the commit cycle itself
  assign count_vld = commit;

endmodule

`default_nettype wire

// ==== hdl/packet_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

// Packet sequencing: load context, run characters, drain, commit
module packet_ctrl_fsm
  import stream_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       pkt_start,
  input  wire logic       pkt_end,
  input  wire stream_id_t stream_id,
  input  wire logic       enable,
  output stream_id_t      cur_stream,
  output logic            cur_enable,
  output logic            load_ctx,
  output logic            run,
  output logic            commit
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  // Stream and enable held for the whole packet
  stream_id_t  stream_q;
  logic        enable_q;

  // Second drain cycle marker
  logic        drain_q;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (pkt_start)
          state_d = LOAD;
      LOAD:
        state_d = RUN;
      RUN:
        if (pkt_end)
          state_d = DRAIN;
      // Two cycles so the last accept lands in the match flag
      DRAIN:
        if (drain_q)
          state_d = COMMIT;
      COMMIT:
        state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= IDLE;
      enable_q <= 1'b0;
      drain_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // pkt_start only counts in IDLE
      if ((state_q == IDLE) && pkt_start)
        enable_q <= enable;
      // Set on the first drain cycle, cleared on leaving
      drain_q <= (state_q == DRAIN) && !drain_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state_q == IDLE) && pkt_start)
      stream_q <= stream_id;
  end

  // In IDLE the live id addresses the stores, so read data is ready in LOAD
  // Afterwards the held id serves the write at commit
  assign cur_stream = (state_q == IDLE) ? stream_id : stream_q;
  assign cur_enable = enable_q;

  // Decoded strobes
  assign load_ctx = (state_q == LOAD);
  assign run      = (state_q == RUN);
  assign commit   = (state_q == COMMIT);

endmodule

`default_nettype wire

// ==== hdl/stream_regex_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Stream-aware "login" matcher
// DFA state and hit count are saved per stream across packets
module stream_regex_top
  import dfa_pkg::*;
  import stream_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       pkt_start,
  input  wire stream_id_t stream_id,
  input  wire logic       new_stream,
  input  wire logic       enable,
  input  wire logic       char_vld,
  input  wire dfa_char_t  char_in,
  input  wire logic       pkt_end,
  output logic            fired,
  output logic            count_vld,
  output hit_count_t      stream_count
);

  // FSM outputs
  stream_id_t cur_stream;
  logic       cur_enable;
  logic       load_ctx;
  logic       run;
  logic       commit;

  // Store read data and the values actually loaded
  dfa_state_t state_rd;
  hit_count_t count_rd;
  dfa_state_t restore_state;
  hit_count_t base_count;

  // DFA side
  logic       dfa_char_vld;
  dfa_state_t next_state;
  logic       accept;

  logic       new_stream_q;
  logic       wr_en;

  // Only the last pkt_start before LOAD matters, which is the accepted one
  always_ff @(posedge clk)
  begin
    if (pkt_start)
      new_stream_q <= new_stream;
  end

  // Fresh stream starts from zero state and zero count
  assign restore_state = new_stream_q ? S_IDLE : state_rd;
  assign base_count    = new_stream_q ? '0 : count_rd;

  // Characters outside RUN are dropped
  assign dfa_char_vld = char_vld && run;

  // Disabled packets leave both stores alone
  assign wr_en = commit && cur_enable;

  packet_ctrl_fsm ctrl_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .pkt_start  (pkt_start),
    .pkt_end    (pkt_end),
    .stream_id  (stream_id),
    .enable     (enable),
    .cur_stream (cur_stream),
    .cur_enable (cur_enable),
    .load_ctx   (load_ctx),
    .run        (run),
    .commit     (commit)
  );

  login_dfa dfa (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_ctx      (load_ctx),
    .restore_state (restore_state),
    .char_vld      (dfa_char_vld),
    .char_in       (char_in),
    .next_state    (next_state),
    .accept        (accept)
  );

  hit_counter counter (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_ctx     (load_ctx),
    .base_count   (base_count),
    .accept       (accept),
    .commit       (commit),
    .cur_enable   (cur_enable),
    .fired        (fired),
    .stream_count (stream_count),
    .count_vld    (count_vld)
  );

  // Saved DFA state per stream
  context_store #(
    .payload_t (dfa_state_t)
  ) state_store (
    .clk     (clk),
    .rd_addr (cur_stream),
    .wr_en   (wr_en),
    .wr_addr (cur_stream),
    .wr_data (next_state),
    .rd_data (state_rd)
  );

  // Saved hit count per stream, written with the updated count
  context_store #(
    .payload_t (hit_count_t)
  ) count_store (
    .clk     (clk),
    .rd_addr (cur_stream),
    .wr_en   (wr_en),
    .wr_addr (cur_stream),
    .wr_data (stream_count),
    .rd_data (count_rd)
  );

endmodule

`default_nettype wire

// ==== tests/stream_regex_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Strobe timing checks on the matcher top level
module stream_regex_checker (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic pkt_start,
  input wire logic pkt_end,
  input wire logic run,
  input wire logic load_ctx,
  input wire logic fired,
  input wire logic count_vld
);

  // One report per packet
  count_vld_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_vld |=> !count_vld
  ) else $error("count_vld high two cycles in a row");

  // Report comes three cycles after an accepted pkt_end, and only then
  count_vld_delay: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_vld == $past(pkt_end && run, 3)
  ) else $error("count_vld not three cycles after pkt_end");

  // LOAD clears the match flag
  fired_cleared: assert property (
    @(posedge clk) disable iff (!rst_n)
    ($past(pkt_start, 2) && $past(load_ctx)) |-> !fired
  ) else $error("fired still set after packet start");

endmodule

bind stream_regex_top stream_regex_checker strobe_checks (
  .clk       (clk),
  .rst_n     (rst_n),
  .pkt_start (pkt_start),
  .pkt_end   (pkt_end),
  .run       (run),
  .load_ctx  (load_ctx),
  .fired     (fired),
  .count_vld (count_vld)
);

`default_nettype wire

// ==== tests/stream_regex_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regex_cfg.svh"

// Directed and random tests for the stream-aware "login" matcher
module stream_regex_tb
  import dfa_pkg::*;
  import stream_pkg::*;
();

  // About 15 directed packets of up to 17 cycles and 40 random ones of up to 19 cycles
  // come to roughly 1020 cycles with reset, so 2000 leaves ample margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk;
  logic       rst_n;
  logic       pkt_start;
  stream_id_t stream_id;
  logic       new_stream;
  logic       enable;
  logic       char_vld;
  dfa_char_t  char_in;
  logic       pkt_end;
  logic       fired;
  logic       count_vld;
  hit_count_t stream_count;

  // Reference copy of each stream's saved context
  dfa_state_t model_state [`NUM_STREAMS];
  hit_count_t model_count [`NUM_STREAMS];
  logic       used [`NUM_STREAMS];

  // DUT values captured at the last count_vld
  hit_count_t last_count;
  logic       last_fired;

  string      test_name;
  integer     seed;
  int         cycle_count = 0;

  stream_regex_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .pkt_start    (pkt_start),
    .stream_id    (stream_id),
    .new_stream   (new_stream),
    .enable       (enable),
    .char_vld     (char_vld),
    .char_in      (char_in),
    .pkt_end      (pkt_end),
    .fired        (fired),
    .count_vld    (count_vld),
    .stream_count (stream_count)
  );

  always #10 clk = ~clk;

  // Run limit
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: no count_vld after %0d cycles in test %s", cycle_count, test_name);
      $display("Simulation failed");
      $fatal(1, "run limit reached");
    end
  end

  // Next state per the word rule with case ignored
  function automatic dfa_state_t model_next(input dfa_state_t cur, input dfa_char_t ch);
    string     word;
    dfa_char_t c;
    int        pos;
    word = "login";
    c = ch;
    if ((c >= 8'h41) && (c <= 8'h5a))
      c = c + 8'h20;
    // After a full word the search restarts from scratch
    pos = (cur == S_MATCH) ? 0 : int'(cur);
    if (c == dfa_char_t'(word[pos]))
      return dfa_state_t'(pos + 1);
    if (c == "l")
      return S_L;
    return S_IDLE;
  endfunction

  task automatic check_count_val(input hit_count_t exp, input hit_count_t act);
    if (exp !== act)
    begin
      $display("[ERROR] %s: stream_count expected %0d, actual %0d", test_name, exp, act);
      $display("Simulation failed");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_fired(input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("[ERROR] %s: fired expected %0b, actual %0b", test_name, exp, act);
      $display("Simulation failed");
      $fatal(1, "fired mismatch");
    end
  endtask

  // Sample the report in the count_vld cycle
  task automatic check_count(input hit_count_t exp_count, input logic exp_fired);
    last_count = stream_count;
    last_fired = fired;
    check_count_val(exp_count, stream_count);
    check_fired(exp_fired, fired);
  endtask

  // One packet through the DUT and checked against the model
  task automatic send_packet(input stream_id_t sid, input logic is_new, input logic en,
                             input string bytes);
    dfa_state_t st;
    hit_count_t exp_count;
    logic       hit;
    int         i;
    st = is_new ? S_IDLE : model_state[sid];
    exp_count = is_new ? '0 : model_count[sid];
    hit = 1'b0;
    for (i = 0; i < bytes.len(); i++)
    begin
      st = model_next(st, dfa_char_t'(bytes[i]));
      if (st == S_MATCH)
        hit = 1'b1;
    end
    if (en && hit)
      exp_count = exp_count + hit_count_t'(1);
    // Disabled packets leave the saved context as it was
    if (en)
    begin
      model_state[sid] = st;
      model_count[sid] = exp_count;
      used[sid] = 1'b1;
    end

    @(posedge clk);
    pkt_start  <= 1'b1;
    stream_id  <= sid;
    new_stream <= is_new;
    enable     <= en;
    @(posedge clk);
    pkt_start <= 1'b0;
    // Stray byte during LOAD that must be dropped
    char_vld  <= 1'b1;
    char_in   <= "l";
    @(posedge clk);
    for (i = 0; i < bytes.len(); i++)
    begin
      char_vld <= 1'b1;
      char_in  <= dfa_char_t'(bytes[i]);
      @(posedge clk);
    end
    char_vld <= 1'b0;
    pkt_end  <= 1'b1;
    @(posedge clk);
    pkt_end <= 1'b0;
    @(negedge clk);
    while (!count_vld)
      @(negedge clk);
    check_count(exp_count, hit);
    // After commit the match flag survives only on an enabled packet
    @(negedge clk);
    check_fired(en && hit, fired);
  endtask

  // New streams with and without a match
  task automatic basic_match();
    test_name = "basic";
    send_packet(stream_id_t'(0), 1'b1, 1'b1, "xxLoGiNyy");
    check_count_val(hit_count_t'(1), last_count);
    check_fired(1'b1, last_fired);
    send_packet(stream_id_t'(1), 1'b1, 1'b1, "logon lgin");
    check_count_val(hit_count_t'(0), last_count);
  endtask

  // Word split over two packets of one stream
  task automatic split_word();
    test_name = "span";
    send_packet(stream_id_t'(2), 1'b1, 1'b1, "xxlo");
    send_packet(stream_id_t'(2), 1'b0, 1'b1, "gin");
    check_count_val(hit_count_t'(1), last_count);
  endtask

  // Two streams with partial words kept apart
  task automatic interleaved_streams();
    test_name = "interleave";
    send_packet(stream_id_t'(3), 1'b1, 1'b1, "log");
    send_packet(stream_id_t'(4), 1'b1, 1'b1, "lo");
    send_packet(stream_id_t'(3), 1'b0, 1'b1, "in");
    check_count_val(hit_count_t'(1), last_count);
    send_packet(stream_id_t'(4), 1'b0, 1'b1, "gi");
    check_count_val(hit_count_t'(0), last_count);
    send_packet(stream_id_t'(4), 1'b0, 1'b1, "n");
    check_count_val(hit_count_t'(1), last_count);
    // Stream 3 sits in S_MATCH so a lone 'n' does nothing
    send_packet(stream_id_t'(3), 1'b0, 1'b1, "n");
    check_count_val(hit_count_t'(1), last_count);
    check_fired(1'b0, last_fired);
  endtask

  // Disabled packet leaves the saved context alone
  task automatic disabled_packet();
    test_name = "disabled";
    send_packet(stream_id_t'(5), 1'b1, 1'b1, "lo");
    send_packet(stream_id_t'(5), 1'b0, 1'b0, "gin");
    check_count_val(hit_count_t'(0), last_count);
    check_fired(1'b1, last_fired);
    // Still resumes from the state saved before the disabled packet
    send_packet(stream_id_t'(5), 1'b0, 1'b1, "gin");
    check_count_val(hit_count_t'(1), last_count);
  endtask

  // new_stream clears both state and count of a used stream
  task automatic stream_restart();
    test_name = "new_stream";
    send_packet(stream_id_t'(0), 1'b0, 1'b1, "lo");
    check_count_val(hit_count_t'(1), last_count);
    send_packet(stream_id_t'(0), 1'b1, 1'b1, "gin");
    check_count_val(hit_count_t'(0), last_count);
    send_packet(stream_id_t'(0), 1'b0, 1'b1, "login");
    check_count_val(hit_count_t'(1), last_count);
  endtask

  // Random packets over streams 8 to 15
  task automatic random_packets();
    string       alphabet;
    string       pkt;
    stream_id_t  sid;
    logic        en;
    logic        is_new;
    logic [31:0] rnd;
    int          len;
    int          idx;
    int          n;
    int          k;
    test_name = "random";
    alphabet = "lLoOgGiInNx";
    for (n = 0; n < 40; n++)
    begin
      rnd = $random(seed);
      sid = stream_id_t'(8 + int'(rnd[2:0]));
      en = rnd[3];
      len = 1 + (int'(rnd[7:4]) % 12);
      // Unused streams must start fresh
      // Used ones restart now and then
      is_new = !used[sid] || (rnd[10:8] == 3'd0);
      pkt = "";
      for (k = 0; k < len; k++)
      begin
        rnd = $random(seed);
        idx = int'(rnd[7:0]) % alphabet.len();
        pkt = {pkt, alphabet.substr(idx, idx)};
      end
      send_packet(sid, is_new, en, pkt);
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    pkt_start  = 1'b0;
    stream_id  = '0;
    new_stream = 1'b0;
    enable     = 1'b0;
    char_vld   = 1'b0;
    char_in    = '0;
    pkt_end    = 1'b0;
    seed       = 38;
    test_name  = "reset";
    for (int s = 0; s < `NUM_STREAMS; s++)
    begin
      model_state[s] = S_IDLE;
      model_count[s] = '0;
      used[s]        = 1'b0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    basic_match();
    split_word();
    interleaved_streams();
    disabled_packet();
    stream_restart();
    random_packets();
    repeat (4) @(posedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/dfa_pkg.sv
hdl/stream_pkg.sv
hdl/context_store.sv
hdl/login_dfa.sv
hdl/hit_counter.sv
hdl/packet_ctrl_fsm.sv
hdl/stream_regex_top.sv
tests/stream_regex_checker.sv
tests/stream_regex_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := stream_regex_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: build
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "FAIL: run ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
